//--- logic/axiRamPkg.sv
package axiRamPkg;

    //////////////////////////////////////////////////
    // Fixed widths
    //////////////////////////////////////////////////

    // Transaction ID width, shared by all channels
    localparam int idWidth = 2;

    // AxLEN carries beat count minus one
    typedef logic [7:0] burstLength;

    //////////////////////////////////////////////////
    // AXI encodings
    //////////////////////////////////////////////////

    // Only FIXED and INCR bursts are handled
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01
    } burstType;

    // Only OKAY is ever returned
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } response;

    // Command fields that travel with AWADDR / ARADDR
    typedef struct packed {
        logic [idWidth-1:0] id;
        burstLength         length;
        burstType           burst;
    } burstCommand;

    //////////////////////////////////////////////////
    // Controller states
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {wrIdle, wrAddress, wrData, wrResponse} writeState;

    typedef enum logic [1:0] {rdIdle, rdAddress, rdStart, rdTransfer} readState;

endpackage

//--- logic/byteLaneRam.sv
`timescale 1ns/1ps

module byteLaneRam
#(
    parameter int addrWidth = 8,
    parameter int dataWidth = 32
)
(
    input  logic                   clock,
    input  logic                   writeEnable,
    input  logic [addrWidth-1:0]   writeAddr,
    input  logic [dataWidth-1:0]   writeData,
    input  logic [dataWidth/8-1:0] writeStrobe,
    input  logic [addrWidth-1:0]   readAddr,
    output logic [dataWidth-1:0]   readData
);
    localparam int bytesPerBeat = dataWidth / 8;

    // One byte per address, whole address space
    logic [7:0] mem [0:2**addrWidth-1];

    // Strobed lanes, address wraps at top of memory
    always_ff @(posedge clock)
    begin
        for (int lane = 0; lane < bytesPerBeat; lane++)
        begin
            if (writeEnable && writeStrobe[lane])
                mem[writeAddr + addrWidth'(lane)] <= writeData[lane*8 +: 8];
        end
    end

    // Combinational read, lane n from base plus n
    for (genvar lane = 0; lane < bytesPerBeat; lane++)
    begin : readLane
        assign readData[lane*8 +: 8] = mem[readAddr + addrWidth'(lane)];
    end

endmodule

//--- logic/axiWriteControl.sv
`timescale 1ns/1ps

module axiWriteControl
#(
    parameter int addrWidth = 8,
    parameter int dataWidth = 32
)
(
    input  logic                             clock,
    input  logic                             resetn,
    input  logic                             awValid,
    input  logic [addrWidth-1:0]             awAddr,
    input  axiRamPkg::burstCommand           awCommand,
    output logic                             awReady,
    input  logic                             wValid,
    input  logic [dataWidth-1:0]             wData,
    input  logic [dataWidth/8-1:0]           wStrobe,
    input  logic                             wLast,
    output logic                             wReady,
    input  logic                             bReady,
    output logic                             bValid,
    output logic [axiRamPkg::idWidth-1:0]    bId,
    output axiRamPkg::response               bResp,
    output logic                             writeEnable,
    output logic [addrWidth-1:0]             writeAddr,
    output logic [dataWidth-1:0]             writeData,
    output logic [dataWidth/8-1:0]           writeStrobe
);
    import axiRamPkg::*;

    localparam int bytesPerBeat = dataWidth / 8;
    localparam int laneWidth    = $clog2(bytesPerBeat);

    writeState          state;
    logic [idWidth-1:0] writeId;
    burstType           writeBurst;
    logic               awHandshake;
    logic               wHandshake;

    assign awHandshake = awValid && awReady;
    assign wHandshake  = wValid && wReady;

    // RAM write port follows the W channel directly
    assign writeEnable = wHandshake;
    assign writeData   = wData;
    assign writeStrobe = wStrobe;

    //////////////////////////////////////////////////
    // Burst address and command
    //////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (awHandshake)
        begin
            // Align down to bus width
            writeAddr  <= {awAddr[addrWidth-1:laneWidth], {laneWidth{1'b0}}};
            writeId    <= awCommand.id;
            writeBurst <= awCommand.burst;
        end
        else if (wHandshake && !wLast && writeBurst == INCR)
            writeAddr <= writeAddr + addrWidth'(bytesPerBeat);
    end

    //////////////////////////////////////////////////
    // Write FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            state   <= wrIdle;
            awReady <= 1'b0;
            wReady  <= 1'b0;
            bValid  <= 1'b0;
            bId     <= '0;
            bResp   <= OKAY;
        end
        else
        begin
            case (state)
                wrIdle:
                begin
                    if (awValid)
                    begin
                        awReady <= 1'b1;
                        state   <= wrAddress;
                    end
                end
                wrAddress:
                begin
                    // Held until the master's valid meets it
                    if (awHandshake)
                    begin
                        awReady <= 1'b0;
                        wReady  <= 1'b1;
                        state   <= wrData;
                    end
                end
                wrData:
                begin
                    if (wHandshake && wLast)
                    begin
                        wReady <= 1'b0;
                        bValid <= 1'b1;
                        bId    <= writeId;
                        bResp  <= OKAY;
                        state  <= wrResponse;
                    end
                end
                wrResponse:
                begin
                    // bId and bResp simply hold
                    if (bReady)
                    begin
                        bValid <= 1'b0;
                        state  <= wrIdle;
                    end
                end
                default:
                    state <= wrIdle;
            endcase
        end
    end

endmodule

//--- logic/axiReadControl.sv
`timescale 1ns/1ps

module axiReadControl
#(
    parameter int addrWidth = 8,
    parameter int dataWidth = 32
)
(
    input  logic                             clock,
    input  logic                             resetn,
    input  logic                             arValid,
    input  logic [addrWidth-1:0]             arAddr,
    input  axiRamPkg::burstCommand           arCommand,
    output logic                             arReady,
    input  logic                             rReady,
    output logic                             rValid,
    output logic [dataWidth-1:0]             rData,
    output logic [axiRamPkg::idWidth-1:0]    rId,
    output axiRamPkg::response               rResp,
    output logic                             rLast,
    output logic [addrWidth-1:0]             readAddr,
    input  logic [dataWidth-1:0]             readData
);
    import axiRamPkg::*;

    localparam int bytesPerBeat = dataWidth / 8;
    localparam int laneWidth    = $clog2(bytesPerBeat);

    readState           state;
    logic [idWidth-1:0] readId;
    burstLength         readLength;
    burstType           readBurst;
    burstLength         beatCount;
    logic               arHandshake;
    logic               rHandshake;
    logic               presentBeat;

    assign arHandshake = arValid && arReady;
    assign rHandshake  = rValid && rReady;

    // A new word goes into rData here
    assign presentBeat = (state == rdStart) || (rHandshake && !rLast);

    //////////////////////////////////////////////////
    // Burst address and command
    //////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (arHandshake)
        begin
            readAddr   <= {arAddr[addrWidth-1:laneWidth], {laneWidth{1'b0}}};
            readId     <= arCommand.id;
            readLength <= arCommand.length;
            readBurst  <= arCommand.burst;
        end
        // Point at the following word once this one is registered
        else if (presentBeat && readBurst == INCR)
            readAddr <= readAddr + addrWidth'(bytesPerBeat);
    end

    //////////////////////////////////////////////////
    // Read FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= rdIdle;
            arReady   <= 1'b0;
            rValid    <= 1'b0;
            rData     <= '0;
            rId       <= '0;
            rResp     <= OKAY;
            rLast     <= 1'b0;
            beatCount <= '0;
        end
        else
        begin
            case (state)
                rdIdle:
                begin
                    if (arValid)
                    begin
                        arReady <= 1'b1;
                        state   <= rdAddress;
                    end
                end
                rdAddress:
                begin
                    if (arHandshake)
                    begin
                        arReady <= 1'b0;
                        state   <= rdStart;
                    end
                end
                rdStart:
                begin
                    // First beat, single-beat burst is last at once
                    rValid    <= 1'b1;
                    rData     <= readData;
                    rId       <= readId;
                    rResp     <= OKAY;
                    rLast     <= (readLength == '0);
                    beatCount <= '0;
                    state     <= rdTransfer;
                end
                rdTransfer:
                begin
                    if (rHandshake && rLast)
                    begin
                        rValid <= 1'b0;
                        rLast  <= 1'b0;
                        rData  <= '0;
                        state  <= rdIdle;
                    end
                    else if (rHandshake)
                    begin
                        // Next beat back to back
                        rData     <= readData;
                        beatCount <= beatCount + 8'd1;
                        rLast     <= (beatCount + 8'd1 == readLength);
                    end
                end
                default:
                    state <= rdIdle;
            endcase
        end
    end

endmodule

//--- logic/axiSlaveRam.sv
`timescale 1ns/1ps

module axiSlaveRam
#(
    parameter int addrWidth = 8,
    parameter int dataWidth = 32
)
(
    input  logic                             clock,
    input  logic                             resetn,
    // AW channel
    input  logic                             awValid,
    output logic                             awReady,
    input  logic [addrWidth-1:0]             awAddr,
    input  axiRamPkg::burstCommand           awCommand,
    // W channel
    input  logic                             wValid,
    output logic                             wReady,
    input  logic [dataWidth-1:0]             wData,
    input  logic [dataWidth/8-1:0]           wStrobe,
    input  logic                             wLast,
    // B channel
    output logic                             bValid,
    input  logic                             bReady,
    output logic [axiRamPkg::idWidth-1:0]    bId,
    output axiRamPkg::response               bResp,
    // AR channel
    input  logic                             arValid,
    output logic                             arReady,
    input  logic [addrWidth-1:0]             arAddr,
    input  axiRamPkg::burstCommand           arCommand,
    // R channel
    output logic                             rValid,
    input  logic                             rReady,
    output logic [dataWidth-1:0]             rData,
    output logic [axiRamPkg::idWidth-1:0]    rId,
    output axiRamPkg::response               rResp,
    output logic                             rLast
);
    // Write side of the RAM
    logic                   writeEnable;
    logic [addrWidth-1:0]   writeAddr;
    logic [dataWidth-1:0]   writeData;
    logic [dataWidth/8-1:0] writeStrobe;

    // Read side, no arbitration needed
    logic [addrWidth-1:0]   readAddr;
    logic [dataWidth-1:0]   readData;

    axiWriteControl #(.addrWidth(addrWidth), .dataWidth(dataWidth)) writeControl_i (
        .clock(clock), .resetn(resetn),
        .awValid(awValid), .awAddr(awAddr), .awCommand(awCommand), .awReady(awReady),
        .wValid(wValid), .wData(wData), .wStrobe(wStrobe), .wLast(wLast), .wReady(wReady),
        .bReady(bReady), .bValid(bValid), .bId(bId), .bResp(bResp),
        .writeEnable(writeEnable), .writeAddr(writeAddr),
        .writeData(writeData), .writeStrobe(writeStrobe)
    );

    axiReadControl #(.addrWidth(addrWidth), .dataWidth(dataWidth)) readControl_i (
        .clock(clock), .resetn(resetn),
        .arValid(arValid), .arAddr(arAddr), .arCommand(arCommand), .arReady(arReady),
        .rReady(rReady), .rValid(rValid), .rData(rData), .rId(rId),
        .rResp(rResp), .rLast(rLast),
        .readAddr(readAddr), .readData(readData)
    );

    byteLaneRam #(.addrWidth(addrWidth), .dataWidth(dataWidth)) ram_i (
        .clock(clock),
        .writeEnable(writeEnable), .writeAddr(writeAddr),
        .writeData(writeData), .writeStrobe(writeStrobe),
        .readAddr(readAddr), .readData(readData)
    );

endmodule

//--- testbench/axiRamChecker.sv
`timescale 1ns/1ps

module axiRamChecker
#(
    parameter int addrWidth = 8,
    parameter int dataWidth = 32
)
(
    input  logic                             clock,
    input  logic                             resetn,
    input  logic                             awValid,
    input  logic                             awReady,
    input  logic [addrWidth-1:0]             awAddr,
    input  axiRamPkg::burstCommand           awCommand,
    input  logic                             wValid,
    input  logic                             wReady,
    input  logic [dataWidth-1:0]             wData,
    input  logic [dataWidth/8-1:0]           wStrobe,
    input  logic                             wLast,
    input  logic                             bValid,
    input  logic                             bReady,
    input  logic [axiRamPkg::idWidth-1:0]    bId,
    input  axiRamPkg::response               bResp,
    input  logic                             arValid,
    input  logic                             arReady,
    input  logic [addrWidth-1:0]             arAddr,
    input  axiRamPkg::burstCommand           arCommand,
    input  logic                             rValid,
    input  logic                             rReady,
    input  logic [dataWidth-1:0]             rData,
    input  logic [axiRamPkg::idWidth-1:0]    rId,
    input  axiRamPkg::response               rResp,
    input  logic                             rLast,
    output int                               mismatchCount,
    output int                               failureCount
);
    import axiRamPkg::*;

    localparam int bytesPerBeat = dataWidth / 8;
    localparam int memBytes     = 2 ** addrWidth;

    // Byte model of the whole memory
    logic [7:0]         modelMem [0:memBytes-1];
    int                 cycle = 0;
    logic               resetCheckDue;

    // Write side
    logic               writeIdle;
    int                 awSeenCycle;
    logic               writeOpen;
    logic               bExpected;
    int                 writeBase;
    burstType           writeBurstType;
    logic [idWidth-1:0] writeId;

    // Read side
    logic               readOpen;
    logic               firstBeatPending;
    int                 arCycle;
    int                 readBase;
    int                 readLength;
    int                 readBeat;
    burstType           readBurstType;
    logic [idWidth-1:0] readId;

    //////////////////////////////////////////////////
    // Address rules and reporting
    //////////////////////////////////////////////////

    // Start address rounded down to a whole beat
    function automatic int alignDown(input logic [addrWidth-1:0] addr);
        return (int'(addr) / bytesPerBeat) * bytesPerBeat;
    endfunction

    // Byte address modulo memory size
    function automatic logic [addrWidth-1:0] byteIndex(input int base, input int lane);
        return addrWidth'((base + lane) % memBytes);
    endfunction

    function automatic logic [dataWidth-1:0] modelWord(input int base);
        logic [dataWidth-1:0] word;
        for (int lane = 0; lane < bytesPerBeat; lane++)
            word[lane*8 +: 8] = modelMem[byteIndex(base, lane)];
        return word;
    endfunction

    task automatic reportMismatch(input string name, input logic [dataWidth-1:0] expected,
                                  input logic [dataWidth-1:0] actual);
        $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        mismatchCount++;
    endtask

    task automatic reportFailure(input string what);
        $display("Error at %0t: %s", $time, what);
        failureCount++;
    endtask

    task automatic expectLow(input string name, input logic value);
        if (value !== 1'b0)
            reportFailure($sformatf("%s is not low just after reset", name));
    endtask

    //////////////////////////////////////////////////
    // Write channels
    //////////////////////////////////////////////////

    task automatic followWrites();
        // awReady due one cycle after awValid is first seen in idle
        if (awValid && awReady)
        begin
            // Ready already up at first sight
            if (writeIdle)
                awSeenCycle = cycle;
            if (cycle != awSeenCycle + 1)
                reportFailure($sformatf("awReady came %0d cycles after awValid, not 1",
                                        cycle - awSeenCycle));
            writeIdle      = 1'b0;
            writeOpen      = 1'b1;
            writeBase      = alignDown(awAddr);
            writeBurstType = awCommand.burst;
            writeId        = awCommand.id;
        end
        else if (writeIdle && awValid)
        begin
            awSeenCycle = cycle;
            writeIdle   = 1'b0;
        end

        // Model update per strobed lane
        if (wValid && wReady)
        begin
            if (!writeOpen)
                reportFailure("W beat accepted while no write burst was open");
            for (int lane = 0; lane < bytesPerBeat; lane++)
            begin
                if (wStrobe[lane])
                    modelMem[byteIndex(writeBase, lane)] = wData[lane*8 +: 8];
            end
            if (wLast)
            begin
                writeOpen = 1'b0;
                bExpected = 1'b1;
            end
            else if (writeBurstType == INCR)
                writeBase = (writeBase + bytesPerBeat) % memBytes;
        end

        if (bValid && bReady)
        begin
            if (!bExpected)
                reportFailure("B response given before the last W beat");
            if (bId !== writeId)
                reportMismatch("bId", dataWidth'(writeId), dataWidth'(bId));
            if (bResp !== OKAY)
                reportMismatch("bResp", dataWidth'(OKAY), dataWidth'(bResp));
            bExpected = 1'b0;
            writeIdle = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // Read channels
    //////////////////////////////////////////////////

    task automatic followReads();
        logic [dataWidth-1:0] expectedData;
        logic                 expectLast;
        // First beat exactly two cycles after AR
        if (firstBeatPending && rValid)
        begin
            if (cycle != arCycle + 2)
                reportFailure($sformatf("first rValid came %0d cycles after AR, not 2",
                                        cycle - arCycle));
            firstBeatPending = 1'b0;
        end

        if (rValid && rReady)
        begin
            if (!readOpen)
                reportFailure("R beat returned while no read burst was open");
            else
            begin
                expectedData = modelWord(readBase);
                expectLast   = (readBeat == readLength);
                if (rData !== expectedData)
                    reportMismatch("rData", expectedData, rData);
                if (rId !== readId)
                    reportMismatch("rId", dataWidth'(readId), dataWidth'(rId));
                if (rResp !== OKAY)
                    reportMismatch("rResp", dataWidth'(OKAY), dataWidth'(rResp));
                if (rLast !== expectLast)
                    reportMismatch("rLast", dataWidth'(expectLast), dataWidth'(rLast));
                if (expectLast)
                    readOpen = 1'b0;
                else
                begin
                    readBeat++;
                    if (readBurstType == INCR)
                        readBase = (readBase + bytesPerBeat) % memBytes;
                end
            end
        end

        if (arValid && arReady)
        begin
            readOpen         = 1'b1;
            readBase         = alignDown(arAddr);
            readLength       = int'(arCommand.length);
            readBurstType    = arCommand.burst;
            readId           = arCommand.id;
            readBeat         = 0;
            arCycle          = cycle;
            firstBeatPending = 1'b1;
        end
    endtask

    // Sampled at the rising edge before DUT updates land
    always @(posedge clock)
    begin
        cycle = cycle + 1;
        if (!resetn)
        begin
            mismatchCount    = 0;
            failureCount     = 0;
            resetCheckDue    = 1'b1;
            writeIdle        = 1'b1;
            writeOpen        = 1'b0;
            bExpected        = 1'b0;
            readOpen         = 1'b0;
            firstBeatPending = 1'b0;
        end
        else
        begin
            // First edge out of reset
            if (resetCheckDue)
            begin
                expectLow("awReady", awReady);
                expectLow("wReady", wReady);
                expectLow("bValid", bValid);
                expectLow("arReady", arReady);
                expectLow("rValid", rValid);
                expectLow("rLast", rLast);
                resetCheckDue = 1'b0;
            end
            followWrites();
            followReads();
        end
    end

endmodule

//--- testbench/axiSlaveRamTb.sv
`timescale 1ns/1ps

module axiSlaveRamTb;
    import axiRamPkg::*;

    localparam int addrWidth   = 8;
    localparam int dataWidth   = 32;
    localparam int lanes       = dataWidth / 8;
    localparam int tableLength = 11;
    localparam int halfPeriod  = 20;
    // Watchdog allowance
    localparam int rowCycles   = 20;
    localparam int beatCycles  = 8;
    localparam logic [31:0] lfsrSeed = 32'h487e;

    // One burst per row
    typedef struct packed {
        logic                 isWrite;
        logic [addrWidth-1:0] addr;
        burstLength           length;
        burstType             burst;
        logic [idWidth-1:0]   id;
        logic [lanes-1:0]     strobe;
        logic [dataWidth-1:0] seed;
    } tableRow;

    //////////////////////////////////////////////////
    // Transaction table
    //////////////////////////////////////////////////

    // Write, addr, length, burst, id, strobe, data seed
    localparam tableRow rows [0:tableLength-1] = '{
        // Unaligned single beat and its read back
        '{1'b1, 8'h12, 8'd0,  INCR,  2'd1, 4'hF,    32'hA5A5_0001},
        '{1'b0, 8'h13, 8'd0,  INCR,  2'd2, 4'h0,    32'h0},
        // Eight beat INCR
        '{1'b1, 8'h20, 8'd7,  INCR,  2'd3, 4'hF,    32'h1000_0000},
        '{1'b0, 8'h20, 8'd7,  INCR,  2'd0, 4'h0,    32'h0},
        // FIXED burst with one lane per beat into a merged word
        '{1'b1, 8'h40, 8'd3,  FIXED, 2'd2, 4'b0001, 32'h4433_2211},
        '{1'b0, 8'h40, 8'd0,  FIXED, 2'd1, 4'h0,    32'h0},
        // Wrap past the top of memory
        '{1'b1, 8'hF4, 8'd5,  INCR,  2'd0, 4'hF,    32'hC0DE_0000},
        '{1'b0, 8'hF8, 8'd3,  INCR,  2'd3, 4'h0,    32'h0},
        '{1'b0, 8'h20, 8'd2,  FIXED, 2'd2, 4'h0,    32'h0},
        // Long burst under back-pressure
        '{1'b1, 8'h80, 8'd15, INCR,  2'd1, 4'hF,    32'h8000_0100},
        '{1'b0, 8'h80, 8'd15, INCR,  2'd0, 4'h0,    32'h0}
    };

    logic                   clock = 1'b0;
    logic                   resetn;
    logic                   awValid;
    logic                   awReady;
    logic [addrWidth-1:0]   awAddr;
    burstCommand            awCommand;
    logic                   wValid;
    logic                   wReady;
    logic [dataWidth-1:0]   wData;
    logic [lanes-1:0]       wStrobe;
    logic                   wLast;
    logic                   bValid;
    logic                   bReady;
    logic [idWidth-1:0]     bId;
    response                bResp;
    logic                   arValid;
    logic                   arReady;
    logic [addrWidth-1:0]   arAddr;
    burstCommand            arCommand;
    logic                   rValid;
    logic                   rReady;
    logic [dataWidth-1:0]   rData;
    logic [idWidth-1:0]     rId;
    response                rResp;
    logic                   rLast;

    // Counts from the checker
    int                     mismatchCount;
    int                     failureCount;
    logic [31:0]            lfsrState;

    axiSlaveRam #(.addrWidth(addrWidth), .dataWidth(dataWidth)) axiSlaveRam_i (.*);

    axiRamChecker #(.addrWidth(addrWidth), .dataWidth(dataWidth)) ramChecker_i (.*);

    always #halfPeriod clock = ~clock;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic takeRandomBit(output logic value);
        lfsrState = lfsrNext(lfsrState);
        value     = lfsrState[0];
    endtask

    // Beat n shifts the pattern up by n lanes
    function automatic logic [lanes-1:0] rotateStrobe(input logic [lanes-1:0] pattern,
                                                      input int beat);
        logic [lanes-1:0] strobe;
        for (int lane = 0; lane < lanes; lane++)
            strobe[(lane + beat) % lanes] = pattern[lane];
        return strobe;
    endfunction

    function automatic int countBeats(input logic writes);
        int total;
        total = 0;
        for (int i = 0; i < tableLength; i++)
        begin
            if (rows[i].isWrite == writes)
                total += int'(rows[i].length) + 1;
        end
        return total;
    endfunction

    task automatic writeBurst(input tableRow row);
        burstCommand command;
        int          beat;
        logic        keepValid;
        logic        ready;
        command.id     = row.id;
        command.length = row.length;
        command.burst  = row.burst;
        awValid   <= 1'b1;
        awAddr    <= row.addr;
        awCommand <= command;
        @(posedge clock);
        while (!awReady)
            @(posedge clock);
        awValid <= 1'b0;
        beat = 0;
        while (beat <= int'(row.length))
        begin
            // Random idle cycle between beats
            takeRandomBit(keepValid);
            if (!keepValid)
            begin
                wValid <= 1'b0;
                wLast  <= 1'b0;
                @(posedge clock);
            end
            else
            begin
                wValid  <= 1'b1;
                wData   <= row.seed + dataWidth'(beat);
                wStrobe <= rotateStrobe(row.strobe, beat);
                wLast   <= (beat == int'(row.length));
                @(posedge clock);
                while (!wReady)
                    @(posedge clock);
                beat++;
            end
        end
        wValid <= 1'b0;
        wLast  <= 1'b0;
        // Random bReady until the response is taken
        takeRandomBit(ready);
        bReady <= ready;
        @(posedge clock);
        while (!(bValid && bReady))
        begin
            takeRandomBit(ready);
            bReady <= ready;
            @(posedge clock);
        end
        bReady <= 1'b0;
    endtask

    task automatic readBurst(input tableRow row);
        burstCommand command;
        int          beat;
        logic        ready;
        command.id     = row.id;
        command.length = row.length;
        command.burst  = row.burst;
        arValid   <= 1'b1;
        arAddr    <= row.addr;
        arCommand <= command;
        @(posedge clock);
        while (!arReady)
            @(posedge clock);
        arValid <= 1'b0;
        beat = 0;
        while (beat <= int'(row.length))
        begin
            takeRandomBit(ready);
            rReady <= ready;
            @(posedge clock);
            if (rValid && rReady)
                beat++;
        end
        rReady <= 1'b0;
    endtask

    task automatic reportAndFinish(input logic timedOut);
        int failures;
        failures = failureCount + (timedOut ? 1 : 0);
        $display("Error counts: %0d mismatches, %0d other failures", mismatchCount, failures);
        if (mismatchCount == 0 && failures == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Stimulus and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        resetn              = 1'b0;
        awValid             = 1'b0;
        awAddr              = '0;
        awCommand           = '0;
        wValid              = 1'b0;
        wData               = '0;
        wStrobe             = '0;
        wLast               = 1'b0;
        bReady              = 1'b0;
        arValid             = 1'b0;
        arAddr              = '0;
        arCommand           = '0;
        rReady              = 1'b0;
        lfsrState           = lfsrSeed;
        repeat (2) @(posedge clock);
        resetn <= 1'b1;
        // Next row only after B or final R
        for (int i = 0; i < tableLength; i++)
        begin
            if (rows[i].isWrite)
                writeBurst(rows[i]);
            else
                readBurst(rows[i]);
        end
        // Let the checker see the last edge
        repeat (2) @(posedge clock);
        reportAndFinish(1'b0);
    end

    initial
    begin : watchdog
        int budget;
        budget = 4 + tableLength * rowCycles + (countBeats(1'b1) + countBeats(1'b0)) * beatCycles;
        repeat (budget) @(posedge clock);
        $display("The run timed out after %0d clock cycles without finishing the table", budget);
        reportAndFinish(1'b1);
    end

endmodule

//--- build.f
logic/axiRamPkg.sv
logic/byteLaneRam.sv
logic/axiWriteControl.sv
logic/axiReadControl.sv
logic/axiSlaveRam.sv
testbench/axiRamChecker.sv
testbench/axiSlaveRamTb.sv

//--- Makefile
TOP = axiSlaveRamTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module axiSlaveRam
	verilator --lint-only --timing -f build.f --top-module $(TOP)

obj_dir/V$(TOP): build.f logic/*.sv testbench/*.sv
	verilator --binary --timing -f build.f --top-module $(TOP) -o V$(TOP)

# Pass only if the pass line shows up in the output
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
